// File: design/nes_loader_pkg.sv
/* Shared constants for the cartridge loader: address map, iNES header
   layout and the loader state encoding */

package nes_loader_pkg;

  // Cartridge memory byte address
  localparam int ADDR_W = 22;

  // iNES header length in bytes
  localparam int HEADER_BYTES = 16;

  // CHR region sits in the upper half of the 4 MB space
  localparam logic [ADDR_W-1:0] CHR_BASE = 22'h200000;

  // Page sizes as shift amounts
  localparam int PRG_PAGE_SHIFT = 14; // 16 KB PRG pages
  localparam int CHR_PAGE_SHIFT = 13; // 8 KB CHR pages

  // "NES" followed by 0x1A, byte 0 in the low bits
  localparam logic [31:0] INES_MAGIC = 32'h1A53454E;

  // Mapper flags word width
  // Bits from 0 upward: mapper 8, prg code 3, chr code 3,
  // mirroring 1, chr ram 1, four screen 1, then zero
  localparam int FLAGS_W = 32;

  // Loader sequence
  typedef enum logic [1:0] {
    ST_HEADER = 2'd0, // Taking the 16 header bytes
    ST_PRG    = 2'd1, // Writing PRG ROM from address 0
    ST_CHR    = 2'd2, // Writing CHR ROM from CHR_BASE
    ST_END    = 2'd3  // Done, with or without error
  } load_state_t;

endpackage

// File: design/ines_header_parser.sv
/* iNES header capture and decode: header validity, page counts and
   the mapper flags word */
`timescale 1ns/100ps

module ines_header_parser (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [7:0]                         in_data,
  input  logic                               capture,          // Take one header byte
  output logic                               header_ok,
  output logic                               last_byte,
  output logic [7:0]                         prg_pages,
  output logic [7:0]                         chr_pages,
  input  logic                               invert_mirroring,
  output logic [nes_loader_pkg::FLAGS_W-1:0] mapper_flags
);

  logic [7:0] ines [0:nes_loader_pkg::HEADER_BYTES-1]; // Raw header bytes
  logic [3:0] idx;       // Next byte slot
  logic       is_nes20;
  logic       is_dirty;
  logic [7:0] mapper;
  logic [2:0] prg_code;
  logic [2:0] chr_code;

  // Smallest n with pages <= 2^n, saturating at 7
  function automatic logic [2:0] size_code(input logic [7:0] pages);
    logic [2:0] code;
    code = 3'd7;
    for (int n = 6; n >= 0; n--) begin
      if (pages <= (8'd1 << n))
        code = 3'(n);
    end
    return code;
  endfunction

  always_ff @(posedge clk) begin
    if (capture)
      ines[idx] <= in_data;
  end

  always_ff @(posedge clk) begin
    if (reset)
      idx <= '0;
    else if (capture)
      idx <= idx + 4'd1; // Wraps after byte 15
  end

  assign last_byte = (idx == 4'(nes_loader_pkg::HEADER_BYTES - 1));

  // Magic in bytes 0..3, trainer flag is byte 6 bit 2
  assign header_ok = ({ines[3], ines[2], ines[1], ines[0]} == nes_loader_pkg::INES_MAGIC)
                     && !ines[6][2];

  assign prg_pages = ines[4]; // 16 KB units
  assign chr_pages = ines[5]; // 8 KB units, zero means CHR RAM

  assign is_nes20 = (ines[7][3:2] == 2'b10);
  // Junk in bytes 8..15 of an old header poisons the high mapper nibble
  assign is_dirty = !is_nes20 && (|{ines[8], ines[9], ines[10], ines[11],
                                    ines[12], ines[13], ines[14], ines[15]});

  assign mapper   = {is_dirty ? 4'b0000 : ines[7][7:4], ines[6][7:4]};
  assign prg_code = size_code(prg_pages);
  assign chr_code = size_code(chr_pages);

  assign mapper_flags = {15'b0,
                         ines[6][3],                    // Four screen
                         (chr_pages == 8'd0),           // CHR RAM
                         ines[6][0] ^ invert_mirroring, // Mirroring
                         chr_code, prg_code, mapper};

endmodule

// File: design/load_byte_counter.sv
/* Bytes remaining in the current ROM section */
`timescale 1ns/100ps

module load_byte_counter (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              load,       // New section length
  input  logic [nes_loader_pkg::ADDR_W-1:0] load_bytes,
  input  logic                              dec,        // One byte written
  output logic                              empty
);

  logic [nes_loader_pkg::ADDR_W-1:0] count;

  // Load wins over dec
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= load_bytes;
    end else if (dec && (count != '0)) begin
      count <= count - 1'b1; // Never wraps below zero
    end
  end

  assign empty = (count == '0);

endmodule

// File: design/load_sequencer.sv
/* Loader FSM: header intake, PRG and CHR sections, done and error */
`timescale 1ns/100ps

module load_sequencer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              in_valid,
  output logic                              in_ready,
  output logic                              capture,     // Header byte into parser
  input  logic                              last_byte,
  input  logic                              header_ok,
  input  logic [7:0]                        prg_pages,
  input  logic [7:0]                        chr_pages,
  output logic                              write_start,
  input  logic                              write_busy,
  output logic                              count_load,
  output logic [nes_loader_pkg::ADDR_W-1:0] count_bytes,
  output logic                              section_chr, // Move address to CHR
  input  logic                              empty,
  output logic                              done,
  output logic                              error
);

  nes_loader_pkg::load_state_t state;
  logic                              in_data_phase;
  logic                              header_end;
  logic [nes_loader_pkg::ADDR_W-1:0] prg_ext;
  logic [nes_loader_pkg::ADDR_W-1:0] chr_ext;

  assign in_data_phase = (state == nes_loader_pkg::ST_PRG) ||
                         (state == nes_loader_pkg::ST_CHR);

  // Header accepts every cycle; data waits for the writer and a nonzero count
  assign in_ready = (state == nes_loader_pkg::ST_HEADER) ||
                    (in_data_phase && !write_busy && !empty);

  assign capture     = (state == nes_loader_pkg::ST_HEADER) && in_valid;
  assign header_end  = capture && last_byte;
  assign write_start = in_data_phase && in_valid && in_ready;

  // Page counts to byte counts
  assign prg_ext = {{(nes_loader_pkg::ADDR_W-8){1'b0}}, prg_pages};
  assign chr_ext = {{(nes_loader_pkg::ADDR_W-8){1'b0}}, chr_pages};

  assign section_chr = (state == nes_loader_pkg::ST_PRG) && empty;
  assign count_load  = (header_end && header_ok) || section_chr;
  assign count_bytes = (state == nes_loader_pkg::ST_HEADER) ?
                       (prg_ext << nes_loader_pkg::PRG_PAGE_SHIFT) :
                       (chr_ext << nes_loader_pkg::CHR_PAGE_SHIFT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= nes_loader_pkg::ST_HEADER;
      done  <= 1'b0;
      error <= 1'b0;
    end else begin
      case (state)
        nes_loader_pkg::ST_HEADER: begin
          if (header_end) begin
            if (header_ok) begin
              state <= nes_loader_pkg::ST_PRG;
            end else begin
              state <= nes_loader_pkg::ST_END; // Bad magic or trainer
              done  <= 1'b1;
              error <= 1'b1;
            end
          end
        end
        nes_loader_pkg::ST_PRG: begin
          if (empty)
            state <= nes_loader_pkg::ST_CHR; // Counter reloads same edge
        end
        nes_loader_pkg::ST_CHR: begin
          if (empty) begin
            state <= nes_loader_pkg::ST_END;
            done  <= 1'b1;
          end
        end
        default: ; // ST_END holds until reset
      endcase
    end
  end

endmodule

// File: design/wb_byte_writer.sv
/* Wishbone classic single-byte write master with its address counter */
`timescale 1ns/100ps

module wb_byte_writer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [7:0]                        in_data,
  input  logic                              write_start,
  input  logic                              section_chr,
  output logic                              write_busy,
  output logic                              byte_done,   // Ack seen, to counter dec
  output logic                              wb_cyc,
  output logic                              wb_stb,
  output logic                              wb_we,
  output logic [nes_loader_pkg::ADDR_W-1:0] wb_adr,
  output logic [7:0]                        wb_dat_o,
  input  logic                              wb_ack
);

  logic                              cyc_q;    // Write in flight
  logic [nes_loader_pkg::ADDR_W-1:0] adr_q;
  logic [7:0]                        dat_q;    // Held byte

  always_ff @(posedge clk) begin
    if (reset) begin
      cyc_q <= 1'b0;
      adr_q <= '0; // PRG starts at zero
    end else if (section_chr) begin
      adr_q <= nes_loader_pkg::CHR_BASE;
    end else if (cyc_q && wb_ack) begin
      cyc_q <= 1'b0;             // Strobe drops the cycle after ack
      adr_q <= adr_q + 1'b1;
    end else if (write_start && !cyc_q) begin
      cyc_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_start && !cyc_q)
      dat_q <= in_data;
  end

  assign write_busy = cyc_q;
  assign byte_done  = cyc_q && wb_ack;

  // Write only, so cyc, stb and we move as one
  assign wb_cyc   = cyc_q;
  assign wb_stb   = cyc_q;
  assign wb_we    = cyc_q;
  assign wb_adr   = adr_q;
  assign wb_dat_o = dat_q;

endmodule

// File: design/cart_loader_top.sv
/* Cartridge loader top: header parser, byte counter, FSM and bus writer */
`timescale 1ns/100ps

module cart_loader_top (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [7:0]                         in_data,
  input  logic                               in_valid,
  output logic                               in_ready,
  input  logic                               invert_mirroring,
  output logic                               wb_cyc,
  output logic                               wb_stb,
  output logic                               wb_we,
  output logic [nes_loader_pkg::ADDR_W-1:0]  wb_adr,
  output logic [7:0]                         wb_dat_o,
  input  logic                               wb_ack,
  output logic [nes_loader_pkg::FLAGS_W-1:0] mapper_flags,
  output logic                               done,
  output logic                               error
);

  logic                              capture;
  logic                              header_ok;
  logic                              last_byte;
  logic [7:0]                        prg_pages;
  logic [7:0]                        chr_pages;
  logic                              write_start;
  logic                              write_busy;
  logic                              byte_done;
  logic                              count_load;
  logic [nes_loader_pkg::ADDR_W-1:0] count_bytes;
  logic                              section_chr;
  logic                              empty;

  ines_header_parser ines_header_parser_i (
    .clk, .reset, .in_data, .capture, .header_ok, .last_byte,
    .prg_pages, .chr_pages, .invert_mirroring, .mapper_flags
  );

  load_byte_counter load_byte_counter_i (
    .clk, .reset, .load(count_load), .load_bytes(count_bytes),
    .dec(byte_done), .empty
  );

  load_sequencer load_sequencer_i (
    .clk, .reset, .in_valid, .in_ready, .capture, .last_byte, .header_ok,
    .prg_pages, .chr_pages, .write_start, .write_busy, .count_load,
    .count_bytes, .section_chr, .empty, .done, .error
  );

  wb_byte_writer wb_byte_writer_i (
    .clk, .reset, .in_data, .write_start, .section_chr, .write_busy,
    .byte_done, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_ack
  );

endmodule

// File: verif/cart_loader_sva.sv
/* Handshake and bus assertions, bound into the loader FSM and the writer */
`timescale 1ns/100ps

module cart_loader_sva (
  input logic                              clk,
  input logic                              reset,
  input nes_loader_pkg::load_state_t       state,
  input logic                              in_ready,
  input logic                              write_busy,
  input logic                              done,
  input logic                              wb_cyc,
  input logic                              wb_stb,
  input logic [nes_loader_pkg::ADDR_W-1:0] wb_adr,
  input logic [7:0]                        wb_dat_o,
  input logic                              wb_ack
);

  stb_in_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else $error("wb_stb high outside a bus cycle");

  // Request frozen until the slave acks
  req_stable: assert property (@(posedge clk) disable iff (reset)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat_o)))
    else $error("write request changed before ack");

  ready_idle: assert property (@(posedge clk) disable iff (reset) write_busy |-> !in_ready)
    else $error("in_ready high during a bus write");

  done_held: assert property (@(posedge clk) disable iff (reset)
    done |=> (done && state == nes_loader_pkg::ST_END))
    else $error("done dropped or FSM left the end state");

endmodule

bind load_sequencer cart_loader_sva seq_sva_i ( // FSM side, bus tied off
  .clk, .reset, .state, .in_ready, .write_busy, .done,
  .wb_cyc(1'b0), .wb_stb(1'b0), .wb_adr('0), .wb_dat_o(8'h00), .wb_ack(1'b0)
);

bind wb_byte_writer cart_loader_sva bus_sva_i ( // Bus side, FSM tied off
  .clk, .reset, .state(nes_loader_pkg::ST_HEADER), .in_ready(1'b0), .write_busy,
  .done(1'b0), .wb_cyc, .wb_stb, .wb_adr, .wb_dat_o, .wb_ack
);

// File: verif/cart_loader_tb.sv
/* Loader testbench: header cases from a pattern file, random payload source,
   Wishbone memory slave with random ack delay and end-of-case checks */
`timescale 1ns/100ps

module cart_loader_tb;

  localparam int CASES  = 8;
  localparam int HDR    = 16;      // iNES header bytes
  localparam int FIELDS = HDR + 3; // Header, invert, flags, error

  logic                               clk = 1'b0;
  logic                               reset = 1'b1;
  logic [7:0]                         in_data = 8'h00;
  logic                               in_valid = 1'b0;
  logic                               in_ready;
  logic                               invert_mirroring = 1'b0;
  logic                               wb_cyc;
  logic                               wb_stb;
  logic                               wb_we;
  logic [nes_loader_pkg::ADDR_W-1:0]  wb_adr;
  logic [7:0]                         wb_dat_o;
  logic                               wb_ack = 1'b0;
  logic [nes_loader_pkg::FLAGS_W-1:0] mapper_flags;
  logic                               done;
  logic                               error;

  logic [31:0] patterns [0:CASES*FIELDS-1];
  logic [15:0] lfsr = 16'd11;
  logic [7:0]  expected_q [$];   // Payload taken, not yet written
  int          cur_case = 0;
  int          prg_total = 0;    // PRG bytes of this case
  int          taken = 0;        // Bytes accepted by the loader
  int          writes = 0;       // Bus writes completed
  int          ack_wait = 0;
  logic        ack_armed = 1'b0; // Delay drawn for this write
  int          cycle_count = 0;
  int          cycle_limit = 0;

  cart_loader_top cart_loader_top_i (
    .clk, .reset, .in_data, .in_valid, .in_ready, .invert_mirroring,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_ack,
    .mapper_flags, .done, .error
  );

  always #5 clk = ~clk;

  // Galois LFSR, one step per bit
  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] r;
    r = 8'h00;
    for (int i = 0; i < n; i++) begin
      r    = {r[6:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic int prg_bytes(input int c);
    return int'(patterns[c*FIELDS+4]) * 16384; // 16 KB pages
  endfunction

  function automatic int payload_bytes(input int c);
    if (patterns[c*FIELDS+18][0])
      return 0; // Rejected header writes nothing
    return prg_bytes(c) + int'(patterns[c*FIELDS+5]) * 8192;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("error: %s is %h, expected %h", name, got, exp));
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
      abort_run($sformatf("timeout: loader not done after %0d cycles", cycle_count));
  end

  always @(posedge clk) begin : source_and_slave
    logic [31:0] exp_adr;
    if (reset) begin
      in_valid  <= 1'b0;
      wb_ack    <= 1'b0;
      taken      = 0;
      writes     = 0;
      ack_armed  = 1'b0;
      expected_q.delete();
    end else begin
      if (in_valid && in_ready) begin // Byte taken this edge
        if (taken >= HDR)
          expected_q.push_back(in_data);
        taken++;
      end
      if (!in_valid || in_ready) begin // Slot free, offer next byte
        if (random_bits(2) == 8'd0) begin
          in_valid <= 1'b0; // Random gap
        end else begin
          in_valid <= 1'b1;
          if (taken < HDR)
            in_data <= patterns[cur_case*FIELDS+taken][7:0];
          else
            in_data <= random_bits(8); // Payload, then surplus past the image
        end
      end
      // Memory slave, ack after 0 to 3 extra cycles
      if (wb_cyc && wb_stb && wb_ack) begin
        exp_adr = (writes < prg_total) ? 32'(writes) :
                  32'(nes_loader_pkg::CHR_BASE) + 32'(writes - prg_total);
        check_value("wb_we", 32'(wb_we), 32'd1);
        check_value("wb_adr", 32'(wb_adr), exp_adr);
        check_value("wb_dat_o", 32'(wb_dat_o), 32'(expected_q.pop_front()));
        writes++;
        wb_ack    <= 1'b0;
        ack_armed  = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!ack_armed) begin
          if (expected_q.size() == 0)
            abort_run("bus write started with no payload byte outstanding");
          ack_armed = 1'b1;
          ack_wait  = int'(random_bits(2));
        end
        if (ack_wait == 0)
          wb_ack <= 1'b1;
        else
          ack_wait--;
      end
    end
  end

  task automatic check_case(input int c);
    int payload;
    payload = payload_bytes(c);
    check_value("error", 32'(error), patterns[c*FIELDS+18]);
    if (!patterns[c*FIELDS+18][0])
      check_value("mapper_flags", mapper_flags, patterns[c*FIELDS+17]);
    check_value("bytes_taken", 32'(taken), 32'(HDR + payload));
    check_value("write_count", 32'(writes), 32'(payload));
    repeat (20) begin // Idle until reset
      @(negedge clk);
      check_value("done", 32'(done), 32'd1);
      check_value("in_ready", 32'(in_ready), 32'd0);
      check_value("wb_cyc", 32'(wb_cyc), 32'd0);
      check_value("wb_stb", 32'(wb_stb), 32'd0);
    end
  endtask

  initial begin : run_cases
    int limit;
    $readmemh("verif/cart_patterns.hex", patterns);
    limit = 1000;
    for (int c = 0; c < CASES; c++)
      limit += (HDR + payload_bytes(c)) * 12;
    cycle_limit = limit;
    for (int c = 0; c < CASES; c++) begin
      @(posedge clk);
      reset            <= 1'b1;
      cur_case         <= c;
      prg_total        <= prg_bytes(c);
      invert_mirroring <= patterns[c*FIELDS+16][0];
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      do @(negedge clk); while (!done);
      check_case(c);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: verif/cart_patterns.hex
// Columns: header bytes 0..15, invert_mirroring, expected mapper_flags, expected error
// Flags are only compared when the expected error is 0
// Mapper 0, 1 PRG, 1 CHR, vertical mirroring
4E 45 53 1A 01 01 01 00 00 00 00 00 00 00 00 00  0  00004000  0
// Mapper 0x41, 2 PRG, mirroring inverted
4E 45 53 1A 02 01 10 40 00 00 00 00 00 00 00 00  1  00004141  0
// Dirty iNES 1.0 tail, high nibble dropped, four screen
4E 45 53 1A 01 01 48 20 69 73 6B 44 75 64 65 21  0  00010004  0
// NES 2.0 with nonzero tail keeps mapper 0x23, mirroring inverted to 0
4E 45 53 1A 01 01 31 28 00 00 07 07 00 00 00 01  1  00000023  0
// CHR RAM, PRG only, mapper 0x12
4E 45 53 1A 01 00 20 10 00 00 00 00 00 00 00 00  1  0000C012  0
// DiskDude tail with byte 7 'D', mapper 0x01, 2 PRG
4E 45 53 1A 02 01 10 44 69 73 6B 44 75 64 65 21  0  00000101  0
// Bad magic byte 3
4E 45 53 1B 01 01 00 00 00 00 00 00 00 00 00 00  0  00000000  1
// Trainer present
4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00  0  00000000  1

// File: verilog.f
design/nes_loader_pkg.sv
design/ines_header_parser.sv
design/load_byte_counter.sv
design/load_sequencer.sv
design/wb_byte_writer.sv
design/cart_loader_top.sv
verif/cart_loader_sva.sv
verif/cart_loader_tb.sv

// File: Makefile
# Verilator build and run of the cartridge loader testbench

TOP := cart_loader_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

obj_dir/V$(TOP): verilog.f design/*.sv verif/*.sv verif/cart_patterns.hex
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

# Result taken from the log, not the exit code of the pipe
test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "no result in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
